//--- logic/gpio_bus_pkg.sv
`default_nettype none

package gpio_bus_pkg;

  // AXI4-Lite bus shape, single 32-bit word per beat
  localparam int addr_bits = 12;
  localparam int data_bits = 32;
  localparam int strb_bits = data_bits / 8;

  // response codes on bresp / rresp
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // slave FSM state codes
  localparam int st_bits = 3;

  localparam logic [st_bits-1:0] st_idle  = 3'd0;
  localparam logic [st_bits-1:0] st_wstrb = 3'd1;  // o_we high
  localparam logic [st_bits-1:0] st_wresp = 3'd2;  // bvalid held
  localparam logic [st_bits-1:0] st_rstrb = 3'd3;  // o_re high
  localparam logic [st_bits-1:0] st_rresp = 3'd4;  // rvalid held

endpackage

`default_nettype wire

//--- logic/gpio_map_pkg.sv
`default_nettype none

package gpio_map_pkg;

  // pins on the block, anything from 1 to 32 works
  localparam int pin_count = 12;

  // word index width, address bits above the byte offset
  localparam int word_bits = gpio_bus_pkg::addr_bits - 2;

  // register word indices, matched against addr[11:2]
  localparam logic [word_bits-1:0] reg_dir  = 10'd0;  // direction, rw
  localparam logic [word_bits-1:0] reg_in   = 10'd1;  // synced pins, ro
  localparam logic [word_bits-1:0] reg_out  = 10'd2;  // output, rw
  localparam logic [word_bits-1:0] reg_mask = 10'd3;  // irq mask, rw
  localparam logic [word_bits-1:0] reg_pend = 10'd4;  // irq pending, w1c

  // all pins start as inputs... direction bit set means input here
  localparam logic [pin_count-1:0] dir_reset = '1;

endpackage

`default_nettype wire

//--- logic/gpio_input_sync.sv
`default_nettype none

module gpio_input_sync (
  input  wire                                 clk,
  input  wire                                 nrst,
  input  wire  [gpio_map_pkg::pin_count-1:0]  i_pins,
  output logic [gpio_map_pkg::pin_count-1:0]  o_sync,
  output logic [gpio_map_pkg::pin_count-1:0]  o_rise
);

  logic [gpio_map_pkg::pin_count-1:0] meta_q;  // first stage, may go metastable
  logic [gpio_map_pkg::pin_count-1:0] sync_q;
  logic [gpio_map_pkg::pin_count-1:0] prev_q;  // last cycle's synced value

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      meta_q <= '0;
      sync_q <= '0;
      prev_q <= '0;
    end else begin
      meta_q <= i_pins;
      sync_q <= meta_q;
      prev_q <= sync_q;
    end
  end

  assign o_sync = sync_q;

  // 0 -> 1 per bit, one cycle wide
  assign o_rise = sync_q & ~prev_q;

endmodule

`default_nettype wire

//--- logic/gpio_regs.sv
`default_nettype none

module gpio_regs (
  input  wire                                 clk,
  input  wire                                 nrst,
  input  wire                                 i_we,
  input  wire  [gpio_bus_pkg::addr_bits-1:0]  i_waddr,
  input  wire  [gpio_bus_pkg::data_bits-1:0]  i_wdata,
  input  wire  [gpio_bus_pkg::strb_bits-1:0]  i_wstrb,
  input  wire                                 i_re,
  input  wire  [gpio_bus_pkg::addr_bits-1:0]  i_raddr,
  output logic [gpio_bus_pkg::data_bits-1:0]  o_rdata,
  output logic                                o_err,
  input  wire  [gpio_map_pkg::pin_count-1:0]  i_sync,
  input  wire  [gpio_map_pkg::pin_count-1:0]  i_rise,
  output logic [gpio_map_pkg::pin_count-1:0]  o_gpio,
  output logic [gpio_map_pkg::pin_count-1:0]  o_gpio_dir,
  output logic [gpio_map_pkg::pin_count-1:0]  o_irq
);

  logic [gpio_map_pkg::pin_count-1:0] dir_q;
  logic [gpio_map_pkg::pin_count-1:0] out_q;
  logic [gpio_map_pkg::pin_count-1:0] mask_q;
  logic [gpio_map_pkg::pin_count-1:0] pend_q;

  logic [gpio_map_pkg::word_bits-1:0] wword;
  logic [gpio_map_pkg::word_bits-1:0] rword;
  logic [gpio_map_pkg::pin_count-1:0] wval;
  logic [gpio_map_pkg::pin_count-1:0] bit_en;
  logic [gpio_map_pkg::pin_count-1:0] pend_clr;
  logic [gpio_map_pkg::pin_count-1:0] rval;
  logic                               w_ok;
  logic                               r_hit;
  logic                               wr_dir;
  logic                               wr_out;
  logic                               wr_mask;
  logic                               wr_pend;

  assign wword = i_waddr[gpio_bus_pkg::addr_bits-1:2];
  assign rword = i_raddr[gpio_bus_pkg::addr_bits-1:2];
  assign wval  = i_wdata[gpio_map_pkg::pin_count-1:0];

  // byte strobe spread onto pin bits
  always_comb begin
    for (int n = 0; n < gpio_map_pkg::pin_count; n++) begin
      bit_en[n] = i_wstrb[n / 8];
    end
  end

  assign wr_dir  = i_we && (wword == gpio_map_pkg::reg_dir);
  assign wr_out  = i_we && (wword == gpio_map_pkg::reg_out);
  assign wr_mask = i_we && (wword == gpio_map_pkg::reg_mask);
  assign wr_pend = i_we && (wword == gpio_map_pkg::reg_pend);

  // input word is read-only, so it is not a valid write target
  assign w_ok = (wword == gpio_map_pkg::reg_dir) || (wword == gpio_map_pkg::reg_out) ||
                (wword == gpio_map_pkg::reg_mask) || (wword == gpio_map_pkg::reg_pend);

  always_comb begin
    rval  = '0;
    r_hit = 1'b1;
    case (rword)
      gpio_map_pkg::reg_dir:  rval = dir_q;
      gpio_map_pkg::reg_in:   rval = i_sync;
      gpio_map_pkg::reg_out:  rval = out_q;
      gpio_map_pkg::reg_mask: rval = mask_q;
      gpio_map_pkg::reg_pend: rval = pend_q;
      default:                r_hit = 1'b0;  // unmapped reads as zero
    endcase
    o_rdata = '0;
    o_rdata[gpio_map_pkg::pin_count-1:0] = rval;
  end

  assign o_err = (i_we && !w_ok) || (i_re && !r_hit);

  assign pend_clr = wr_pend ? (wval & bit_en) : '0;

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      dir_q  <= gpio_map_pkg::dir_reset;
      out_q  <= '0;
      mask_q <= '0;
      pend_q <= '0;
    end else begin
      if (wr_dir) begin
        dir_q <= (dir_q & ~bit_en) | (wval & bit_en);
      end
      if (wr_out) begin
        out_q <= (out_q & ~bit_en) | (wval & bit_en);
      end
      if (wr_mask) begin
        mask_q <= (mask_q & ~bit_en) | (wval & bit_en);
      end
      pend_q <= (pend_q & ~pend_clr) | i_rise;  // new edge beats the clear
    end
  end

  assign o_gpio     = out_q;
  assign o_gpio_dir = dir_q;
  assign o_irq      = pend_q & mask_q;

endmodule

`default_nettype wire

//--- logic/axil_slave_fsm.sv
`default_nettype none

module axil_slave_fsm (
  input  wire                                   clk,
  input  wire                                   nrst,
  input  wire                                   i_awvalid,
  input  wire  [gpio_bus_pkg::addr_bits-1:0]    i_awaddr,
  input  wire                                   i_wvalid,
  input  wire  [gpio_bus_pkg::data_bits-1:0]    i_wdata,
  input  wire  [gpio_bus_pkg::strb_bits-1:0]    i_wstrb,
  output logic                                  o_awready,
  output logic                                  o_wready,
  output logic                                  o_bvalid,
  output logic [1:0]                            o_bresp,
  input  wire                                   i_bready,
  input  wire                                   i_arvalid,
  input  wire  [gpio_bus_pkg::addr_bits-1:0]    i_araddr,
  output logic                                  o_arready,
  output logic                                  o_rvalid,
  output logic [gpio_bus_pkg::data_bits-1:0]    o_rdata,
  output logic [1:0]                            o_rresp,
  input  wire                                   i_rready,
  output logic                                  o_we,
  output logic [gpio_bus_pkg::addr_bits-1:0]    o_waddr,
  output logic [gpio_bus_pkg::data_bits-1:0]    o_wdata,
  output logic [gpio_bus_pkg::strb_bits-1:0]    o_wstrb,
  output logic                                  o_re,
  output logic [gpio_bus_pkg::addr_bits-1:0]    o_raddr,
  input  wire  [gpio_bus_pkg::data_bits-1:0]    i_rdata,
  input  wire                                   i_err
);

  logic [gpio_bus_pkg::st_bits-1:0] state;
  logic [gpio_bus_pkg::st_bits-1:0] state_nxt;

  logic                                wr_acc;
  logic                                rd_acc;
  logic [gpio_bus_pkg::addr_bits-1:0]  waddr_q;
  logic [gpio_bus_pkg::data_bits-1:0]  wdata_q;
  logic [gpio_bus_pkg::strb_bits-1:0]  wstrb_q;
  logic [gpio_bus_pkg::addr_bits-1:0]  raddr_q;
  logic [gpio_bus_pkg::data_bits-1:0]  rdata_q;
  logic [1:0]                          bresp_q;
  logic [1:0]                          rresp_q;

  // write needs both channels at once, and beats a read in the same cycle
  assign wr_acc = (state == gpio_bus_pkg::st_idle) && i_awvalid && i_wvalid;
  assign rd_acc = (state == gpio_bus_pkg::st_idle) && i_arvalid && !(i_awvalid && i_wvalid);

  assign o_awready = wr_acc;
  assign o_wready  = wr_acc;
  assign o_arready = rd_acc;

  always_comb begin
    state_nxt = state;
    case (state)
      gpio_bus_pkg::st_idle: begin
        if (wr_acc) begin
          state_nxt = gpio_bus_pkg::st_wstrb;
        end else if (rd_acc) begin
          state_nxt = gpio_bus_pkg::st_rstrb;
        end
      end
      gpio_bus_pkg::st_wstrb: state_nxt = gpio_bus_pkg::st_wresp;
      gpio_bus_pkg::st_wresp: begin
        if (i_bready) begin
          state_nxt = gpio_bus_pkg::st_idle;
        end
      end
      gpio_bus_pkg::st_rstrb: state_nxt = gpio_bus_pkg::st_rresp;
      gpio_bus_pkg::st_rresp: begin
        if (i_rready) begin
          state_nxt = gpio_bus_pkg::st_idle;
        end
      end
      default: state_nxt = gpio_bus_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      state <= gpio_bus_pkg::st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // request payload, latched on the accepting edge
  always_ff @(posedge clk) begin
    if (wr_acc) begin
      waddr_q <= i_awaddr;
      wdata_q <= i_wdata;
      wstrb_q <= i_wstrb;
    end
    if (rd_acc) begin
      raddr_q <= i_araddr;
    end
  end

  // register block answers combinationally during the strobe cycle
  always_ff @(posedge clk) begin
    if (state == gpio_bus_pkg::st_wstrb) begin
      bresp_q <= i_err ? gpio_bus_pkg::resp_slverr : gpio_bus_pkg::resp_okay;
    end
    if (state == gpio_bus_pkg::st_rstrb) begin
      rdata_q <= i_rdata;
      rresp_q <= i_err ? gpio_bus_pkg::resp_slverr : gpio_bus_pkg::resp_okay;
    end
  end

  assign o_we    = (state == gpio_bus_pkg::st_wstrb);
  assign o_re    = (state == gpio_bus_pkg::st_rstrb);
  assign o_waddr = waddr_q;
  assign o_wdata = wdata_q;
  assign o_wstrb = wstrb_q;
  assign o_raddr = raddr_q;

  assign o_bvalid = (state == gpio_bus_pkg::st_wresp);
  assign o_bresp  = bresp_q;
  assign o_rvalid = (state == gpio_bus_pkg::st_rresp);
  assign o_rdata  = rdata_q;
  assign o_rresp  = rresp_q;

endmodule

`default_nettype wire

//--- logic/gpio_top.sv
`default_nettype none

module gpio_top (
  input  wire                                 clk,
  input  wire                                 nrst,
  input  wire                                 i_awvalid,
  input  wire  [gpio_bus_pkg::addr_bits-1:0]  i_awaddr,
  output logic                                o_awready,
  input  wire                                 i_wvalid,
  input  wire  [gpio_bus_pkg::data_bits-1:0]  i_wdata,
  input  wire  [gpio_bus_pkg::strb_bits-1:0]  i_wstrb,
  output logic                                o_wready,
  output logic                                o_bvalid,
  output logic [1:0]                          o_bresp,
  input  wire                                 i_bready,
  input  wire                                 i_arvalid,
  input  wire  [gpio_bus_pkg::addr_bits-1:0]  i_araddr,
  output logic                                o_arready,
  output logic                                o_rvalid,
  output logic [gpio_bus_pkg::data_bits-1:0]  o_rdata,
  output logic [1:0]                          o_rresp,
  input  wire                                 i_rready,
  input  wire  [gpio_map_pkg::pin_count-1:0]  i_gpio,
  output logic [gpio_map_pkg::pin_count-1:0]  o_gpio,
  output logic [gpio_map_pkg::pin_count-1:0]  o_gpio_dir,
  output logic [gpio_map_pkg::pin_count-1:0]  o_irq
);

  logic                                we;
  logic [gpio_bus_pkg::addr_bits-1:0]  waddr;
  logic [gpio_bus_pkg::data_bits-1:0]  wdata;
  logic [gpio_bus_pkg::strb_bits-1:0]  wstrb;
  logic                                re;
  logic [gpio_bus_pkg::addr_bits-1:0]  raddr;
  logic [gpio_bus_pkg::data_bits-1:0]  reg_rdata;
  logic                                reg_err;
  logic [gpio_map_pkg::pin_count-1:0]  pin_sync;
  logic [gpio_map_pkg::pin_count-1:0]  pin_rise;

  axil_slave_fsm fsm0 (
    .clk       (clk),
    .nrst      (nrst),
    .i_awvalid (i_awvalid),
    .i_awaddr  (i_awaddr),
    .i_wvalid  (i_wvalid),
    .i_wdata   (i_wdata),
    .i_wstrb   (i_wstrb),
    .o_awready (o_awready),
    .o_wready  (o_wready),
    .o_bvalid  (o_bvalid),
    .o_bresp   (o_bresp),
    .i_bready  (i_bready),
    .i_arvalid (i_arvalid),
    .i_araddr  (i_araddr),
    .o_arready (o_arready),
    .o_rvalid  (o_rvalid),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp),
    .i_rready  (i_rready),
    .o_we      (we),
    .o_waddr   (waddr),
    .o_wdata   (wdata),
    .o_wstrb   (wstrb),
    .o_re      (re),
    .o_raddr   (raddr),
    .i_rdata   (reg_rdata),
    .i_err     (reg_err)
  );

  gpio_regs regs0 (
    .clk        (clk),
    .nrst       (nrst),
    .i_we       (we),
    .i_waddr    (waddr),
    .i_wdata    (wdata),
    .i_wstrb    (wstrb),
    .i_re       (re),
    .i_raddr    (raddr),
    .o_rdata    (reg_rdata),
    .o_err      (reg_err),
    .i_sync     (pin_sync),
    .i_rise     (pin_rise),
    .o_gpio     (o_gpio),
    .o_gpio_dir (o_gpio_dir),
    .o_irq      (o_irq)
  );

  // pins are asynchronous to clk
  gpio_input_sync sync0 (
    .clk    (clk),
    .nrst   (nrst),
    .i_pins (i_gpio),
    .o_sync (pin_sync),
    .o_rise (pin_rise)
  );

endmodule

`default_nettype wire

//--- verification/gpio_tb_assertions.sv
`default_nettype none

module gpio_tb_assertions (
  input wire                                clk,
  input wire                                nrst,
  input wire                                i_awready,
  input wire                                i_arready,
  input wire                                i_bvalid,
  input wire                                i_bready,
  input wire [1:0]                          i_bresp,
  input wire                                i_rvalid,
  input wire                                i_rready,
  input wire [gpio_bus_pkg::data_bits-1:0]  i_rdata,
  input wire [1:0]                          i_rresp,
  input wire                                i_we,
  input wire                                i_re,
  input wire [gpio_map_pkg::pin_count-1:0]  i_rise,
  input wire [gpio_map_pkg::pin_count-1:0]  i_mask,
  input wire [gpio_map_pkg::pin_count-1:0]  i_irq,
  input wire [gpio_map_pkg::pin_count-1:0]  i_gpio_dir
);

  int fail_count = 0;  // read by the testbench at the end

  bvalid_held: assert property (@(posedge clk) disable iff (!nrst)
    i_bvalid && !i_bready |=> i_bvalid && $stable(i_bresp))
    else begin
      fail_count++;
      $error("bvalid or bresp changed before bready");
    end

  rvalid_held: assert property (@(posedge clk) disable iff (!nrst)
    i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata) && $stable(i_rresp))
    else begin
      fail_count++;
      $error("rvalid, rdata or rresp changed before rready");
    end

  no_accept_busy: assert property (@(posedge clk) disable iff (!nrst)
    (i_bvalid || i_rvalid) |-> !i_awready && !i_arready)
    else begin
      fail_count++;
      $error("request accepted while a response was pending");
    end

  strobe_excl: assert property (@(posedge clk) !(i_we && i_re))
    else begin
      fail_count++;
      $error("write and read strobe high together");
    end

  reset_state: assert property (@(posedge clk)
    $rose(nrst) |-> !i_bvalid && !i_rvalid && (i_gpio_dir == '1))
    else begin
      fail_count++;
      $error("outputs not at reset values after reset");
    end

  irq_rule: assert property (@(posedge clk) disable iff (!nrst)
    i_rise != '0 |=> ($past(i_rise) & i_mask & ~i_irq) == '0)
    else begin
      fail_count++;
      $error("rising edge on a masked pin did not raise o_irq");
    end

endmodule

bind gpio_top gpio_tb_assertions asrt0 (
  .clk        (clk),
  .nrst       (nrst),
  .i_awready  (o_awready),
  .i_arready  (o_arready),
  .i_bvalid   (o_bvalid),
  .i_bready   (i_bready),
  .i_bresp    (o_bresp),
  .i_rvalid   (o_rvalid),
  .i_rready   (i_rready),
  .i_rdata    (o_rdata),
  .i_rresp    (o_rresp),
  .i_we       (we),
  .i_re       (re),
  .i_rise     (pin_rise),
  .i_mask     (regs0.mask_q),
  .i_irq      (o_irq),
  .i_gpio_dir (o_gpio_dir)
);

`default_nettype wire

//--- verification/gpio_tb.sv
`default_nettype none

module gpio_tb;

  logic                                clk;
  logic                                nrst;
  logic                                awvalid;
  logic                                wvalid;
  logic                                arvalid;
  logic                                bready;
  logic                                rready;
  logic [gpio_bus_pkg::addr_bits-1:0]  awaddr;
  logic [gpio_bus_pkg::addr_bits-1:0]  araddr;
  logic [gpio_bus_pkg::data_bits-1:0]  wdata;
  logic [gpio_bus_pkg::strb_bits-1:0]  wstrb;
  logic [gpio_map_pkg::pin_count-1:0]  pins;
  wire                                 awready;
  wire                                 wready;
  wire                                 arready;
  wire                                 bvalid;
  wire                                 rvalid;
  wire  [1:0]                          bresp;
  wire  [1:0]                          rresp;
  wire  [gpio_bus_pkg::data_bits-1:0]  rdata;
  wire  [gpio_map_pkg::pin_count-1:0]  gpio_out;
  wire  [gpio_map_pkg::pin_count-1:0]  gpio_dir;
  wire  [gpio_map_pkg::pin_count-1:0]  irq;

  logic [15:0] lfsr_q;
  logic [31:0] pin_mask;
  logic [31:0] dir_m;  // expected register state
  logic [31:0] out_m;
  logic [31:0] mask_m;
  logic [31:0] pend_m;
  logic [31:0] pins_m;
  int          mismatches;
  int          timeouts;

  gpio_top dut0 (
    .clk(clk), .nrst(nrst),
    .i_awvalid(awvalid), .i_awaddr(awaddr), .o_awready(awready),
    .i_wvalid(wvalid), .i_wdata(wdata), .i_wstrb(wstrb), .o_wready(wready),
    .o_bvalid(bvalid), .o_bresp(bresp), .i_bready(bready),
    .i_arvalid(arvalid), .i_araddr(araddr), .o_arready(arready),
    .o_rvalid(rvalid), .o_rdata(rdata), .o_rresp(rresp), .i_rready(rready),
    .i_gpio(pins), .o_gpio(gpio_out), .o_gpio_dir(gpio_dir), .o_irq(irq)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic lfsr_step_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) begin
      lfsr_q = lfsr_q ^ 16'hb400;  // x^16 + x^14 + x^13 + x^11 + 1
    end
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_step_bit()};
    end
    return v;
  endfunction

  // byte lanes with strobe set take the new data
  function automatic logic [31:0] strobe_merge(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] strb);
    logic [31:0] v;
    v = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        v[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return v;
  endfunction

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      mismatches++;
      $display("mismatch at %0t: %s is %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  // random ready on the pending response, new requests offered only while it stalls
  task automatic pick_ready(input logic is_wr);
    logic take;
    take = lfsr_step_bit();
    bready  <= is_wr && take;
    rready  <= !is_wr && take;
    awvalid <= !take;
    wvalid  <= !take;
    arvalid <= !take;
  endtask

  // one AXI-Lite write or read, ready stalled at random while the response waits
  task automatic bus_xfer(input logic is_wr, input logic [11:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, output logic [31:0] rd, output logic [1:0] resp);
    int   n;
    logic done;
    rd   = '0;
    resp = 2'b11;
    n    = 0;
    done = 1'b0;
    @(posedge clk);
    awvalid <= is_wr;
    wvalid  <= is_wr;
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= strb;
    arvalid <= !is_wr;
    araddr  <= addr;
    while (!done && n < 50) begin
      @(negedge clk);
      done = is_wr ? (awready && wready) : arready;
      n++;
    end
    @(posedge clk);  // handshake edge
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    arvalid <= 1'b0;
    if (!done) begin
      timeouts++;
      $display("timeout at %0t: request to address %03h was never accepted", $time, addr);
    end else begin
      pick_ready(is_wr);
      n    = 0;
      done = 1'b0;
      while (!done && n < 50) begin
        @(negedge clk);
        if (is_wr ? (bvalid && bready) : (rvalid && rready)) begin
          done = 1'b1;
          resp = is_wr ? bresp : rresp;
          rd   = rdata;
        end else begin
          @(posedge clk);
          pick_ready(is_wr);
          n++;
        end
      end
      @(posedge clk);
      bready  <= 1'b0;
      rready  <= 1'b0;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      arvalid <= 1'b0;
      if (!done) begin
        timeouts++;
        $display("timeout at %0t: no response for address %03h", $time, addr);
      end
    end
  endtask

  task automatic write_expect(input logic [11:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input logic [1:0] exp_resp);
    logic [31:0] rd;
    logic [1:0]  resp;
    bus_xfer(1'b1, addr, data, strb, rd, resp);
    check_word("bresp", 32'(resp), 32'(exp_resp));
  endtask

  task automatic read_expect(input logic [11:0] addr, input logic [31:0] exp,
                             input logic [1:0] exp_resp);
    logic [31:0] rd;
    logic [1:0]  resp;
    bus_xfer(1'b0, addr, '0, '0, rd, resp);
    check_word($sformatf("read %03h", addr), rd, exp);
    check_word("rresp", 32'(resp), 32'(exp_resp));
  endtask

  task automatic check_outputs();
    @(negedge clk);
    check_word("o_gpio", 32'(gpio_out), out_m);
    check_word("o_gpio_dir", 32'(gpio_dir), dir_m);
    check_word("o_irq", 32'(irq), pend_m & mask_m);
  endtask

  task automatic check_rw_regs();
    read_expect(12'h000, dir_m, 2'b00);
    read_expect(12'h008, out_m, 2'b00);
    read_expect(12'h00c, mask_m, 2'b00);
    read_expect(12'h010, pend_m, 2'b00);
  endtask

  // poll the input register until the driven pins show up
  task automatic drive_pins(input logic [31:0] val);
    logic [31:0] rd;
    logic [1:0]  resp;
    int          n;
    @(posedge clk);
    pins <= val[gpio_map_pkg::pin_count-1:0];
    pend_m = pend_m | (val & ~pins_m);  // 0 -> 1 sets pending
    pins_m = val;
    n  = 0;
    rd = ~val;
    while (rd !== val && n < 20) begin
      bus_xfer(1'b0, 12'h004, '0, '0, rd, resp);
      n++;
    end
    if (rd !== val) begin
      timeouts++;
      $display("timeout at %0t: input register never showed pins %08h", $time, val);
    end
  endtask

  initial begin
    logic [31:0] data;
    logic [3:0]  strb;
    logic [11:0] addr;
    logic [1:0]  sel;
    lfsr_q     = 16'd13117;
    mismatches = 0;
    timeouts   = 0;
    pin_mask   = '0;
    for (int k = 0; k < gpio_map_pkg::pin_count; k++) begin
      pin_mask[k] = 1'b1;
    end
    nrst <= 1'b0;
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    arvalid <= 1'b0;
    bready <= 1'b0;
    rready <= 1'b0;
    awaddr <= '0;
    araddr <= '0;
    wdata <= '0;
    wstrb <= '0;
    pins <= '0;
    dir_m  = pin_mask;  // all pins inputs out of reset
    out_m  = '0;
    mask_m = '0;
    pend_m = '0;
    pins_m = '0;
    repeat (5) @(posedge clk);
    nrst <= 1'b1;

    check_outputs();
    check_rw_regs();

    repeat (24) begin
      sel  = 2'(rand_bits(2));
      data = rand_bits(32);
      strb = 4'(rand_bits(4));
      addr = (sel == 2'd0) ? 12'h000 : (sel == 2'd1) ? 12'h008 : 12'h00c;
      write_expect(addr, data, strb, 2'b00);
      if (sel == 2'd0) dir_m = strobe_merge(dir_m, data, strb) & pin_mask;
      else if (sel == 2'd1) out_m = strobe_merge(out_m, data, strb) & pin_mask;
      else mask_m = strobe_merge(mask_m, data, strb) & pin_mask;
      check_outputs();
      read_expect(addr, (sel == 2'd0) ? dir_m : (sel == 2'd1) ? out_m : mask_m, 2'b00);
    end

    drive_pins(rand_bits(32) & pin_mask);
    read_expect(12'h004, pins_m, 2'b00);
    write_expect(12'h004, rand_bits(32), 4'hf, 2'b10);  // read-only word
    addr = 12'h014 | 12'(rand_bits(10) << 2);
    write_expect(addr, rand_bits(32), 4'hf, 2'b10);
    read_expect(addr, '0, 2'b10);
    read_expect(12'h004, pins_m, 2'b00);
    check_rw_regs();

    data = rand_bits(32);
    write_expect(12'h00c, data, 4'hf, 2'b00);
    mask_m = data & pin_mask;
    drive_pins('0);
    write_expect(12'h010, 32'hffff_ffff, 4'hf, 2'b00);
    pend_m = '0;
    check_outputs();
    repeat (4) begin
      drive_pins(rand_bits(32) & pin_mask);
      check_outputs();
      read_expect(12'h010, pend_m, 2'b00);
      data = rand_bits(32);
      strb = 4'(rand_bits(4));
      write_expect(12'h010, data, strb, 2'b00);
      pend_m = pend_m & ~strobe_merge('0, data, strb);
      check_outputs();
      check_rw_regs();
      drive_pins('0);
    end

    $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatches, timeouts, dut0.asrt0.fail_count);
    if (mismatches == 0 && timeouts == 0 && dut0.asrt0.fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
logic/gpio_bus_pkg.sv
logic/gpio_map_pkg.sv
logic/gpio_input_sync.sv
logic/gpio_regs.sv
logic/axil_slave_fsm.sv
logic/gpio_top.sv
verification/gpio_tb_assertions.sv
verification/gpio_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the GPIO testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module gpio_tb -o gpio_sim

# keep running after an assertion error so the testbench prints its result line
./obj_dir/gpio_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"
